// ==== list.f ====
+incdir+tb
logic/dq_fmt_pkg.sv
logic/dq_seq_pkg.sv
logic/dq_ctrl.sv
logic/int8_mac.sv
logic/scale_combine.sv
logic/dequantize_elem.sv
logic/dq_top.sv
tb/tb_dq_top.sv

// ==== logic/dequantize_elem.sv ====
`timescale 1ns/1ps
`default_nettype none

// int32 accumulator to fp32 with a combined scale
// correction multiply, leading-one search and renormalize all combinational,
// only the final word is registered on ld_i
module dequantize_elem (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              ld_i,
    input  dq_fmt_pkg::acc_t  acc_i,
    input  dq_fmt_pkg::mant_t mant_scale_i,
    input  dq_fmt_pkg::exp_t  exp_scale_i,
    output dq_fmt_pkg::fp32_t result_o
);

    logic                                          acc_sign;
    logic [dq_fmt_pkg::ACC_W-1:0]                  acc_abs;
    logic                                          acc_is_zero;
    logic [dq_fmt_pkg::SCALE_MANT_W:0]             scale_sig;   // 1.xxx, 16 bits
    logic [dq_fmt_pkg::ACC_W+dq_fmt_pkg::SCALE_MANT_W:0] prod;  // 48 bits
    logic [2*dq_fmt_pkg::ACC_W-1:0]                prod_cor;    // 64 bits
    logic [dq_fmt_pkg::ACC_W-2:0]                  scaled;      // 31 bits
    logic [$clog2(dq_fmt_pkg::ACC_W)-1:0]          msb_pos;
    logic [dq_fmt_pkg::ACC_W-2:0]                  norm;
    dq_fmt_pkg::mant_t                             mant_final;
    logic signed [dq_fmt_pkg::EXP_W+1:0]           exp_temp;
    dq_fmt_pkg::exp_t                              exp_final;
    dq_fmt_pkg::fp32_t                             result_d;
    dq_fmt_pkg::fp32_t                             result_q;

    assign acc_sign    = acc_i[dq_fmt_pkg::ACC_W-1];
    assign acc_abs     = acc_sign ? -acc_i : acc_i;
    assign acc_is_zero = (acc_i == '0);

    assign scale_sig = {1'b1,
                        mant_scale_i[dq_fmt_pkg::MANT_W-1 -: dq_fmt_pkg::SCALE_MANT_W]};

    assign prod     = acc_abs * scale_sig;
    assign prod_cor = {{(dq_fmt_pkg::ACC_W-dq_fmt_pkg::SCALE_MANT_W-1){1'b0}}, prod}
                    * (2*dq_fmt_pkg::ACC_W)'(dq_fmt_pkg::CORR_MULT);

    // >> CORR_SHIFT, keep 31 bits
    assign scaled = prod_cor[dq_fmt_pkg::CORR_SHIFT +: dq_fmt_pkg::ACC_W-1];

    // leading one, last hit in the loop is the highest set bit
    always_comb begin
        msb_pos = '0;
        for (int i = 0; i < dq_fmt_pkg::ACC_W-1; i++) begin
            if (scaled[i]) begin
                msb_pos = i[$clog2(dq_fmt_pkg::ACC_W)-1:0];
            end
        end
    end

    // bring the leading one to bit 23
    always_comb begin
        if (msb_pos >= dq_fmt_pkg::MANT_W) begin
            norm = scaled >> (msb_pos - dq_fmt_pkg::MANT_W);
        end else begin
            norm = scaled << (dq_fmt_pkg::MANT_W - msb_pos);
        end
    end

    assign mant_final = norm[dq_fmt_pkg::MANT_W-1:0];  // hidden one dropped, truncated

    assign exp_temp = $signed({2'b00, exp_scale_i})
                    + $signed({{(dq_fmt_pkg::EXP_W+2-$clog2(dq_fmt_pkg::ACC_W)){1'b0}}, msb_pos})
                    - (dq_fmt_pkg::EXP_W+2)'(dq_fmt_pkg::EXP_OFFSET);

    // clamp to 0..EXP_MAX
    always_comb begin
        if (exp_temp < 0) begin
            exp_final = '0;
        end else if (exp_temp > dq_fmt_pkg::EXP_MAX) begin
            exp_final = dq_fmt_pkg::EXP_MAX[dq_fmt_pkg::EXP_W-1:0];
        end else begin
            exp_final = exp_temp[dq_fmt_pkg::EXP_W-1:0];
        end
    end

    assign result_d = acc_is_zero ? '0 : {acc_sign, exp_final, mant_final};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_q <= '0;
        end else if (ld_i) begin
            result_q <= result_d;  // held until the next load
        end
    end

    assign result_o = result_q;

endmodule

`default_nettype wire

// ==== logic/dq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// control for one operation
// start (idle only) -> accumulate samples -> one convert cycle -> result strobe
//
// timing seen from the last-sample edge E0
//   E0  final product added, state goes to ST_CONV
//   E1  dequantizer output registers, result_valid_o rises, busy_o falls
// so a check sampling on rising edges sees result_valid_o at E0 + RESULT_LAT
module dq_ctrl (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic start_i,
    input  logic sample_valid_i,
    input  logic last_i,
    output logic acc_clr_o,
    output logic acc_en_o,
    output logic scale_ld_o,
    output logic res_ld_o,
    output logic result_valid_o,
    output logic busy_o
);

    dq_seq_pkg::ctrl_state_t state_q;
    dq_seq_pkg::ctrl_state_t state_d;

    logic start_acc;   // start accepted this edge
    logic sample_acc;  // sample accepted this edge
    logic last_acc;

    assign start_acc  = (state_q == dq_seq_pkg::ST_IDLE) && start_i;
    assign sample_acc = (state_q == dq_seq_pkg::ST_ACC) && sample_valid_i;
    assign last_acc   = sample_acc && last_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dq_seq_pkg::ST_IDLE: begin
                if (start_acc) begin
                    state_d = dq_seq_pkg::ST_ACC;
                end
            end
            dq_seq_pkg::ST_ACC: begin
                if (last_acc) begin
                    state_d = dq_seq_pkg::ST_CONV;
                end
            end
            dq_seq_pkg::ST_CONV: begin
                state_d = dq_seq_pkg::ST_IDLE;  // never more than one cycle
            end
            default: begin
                state_d = dq_seq_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= dq_seq_pkg::ST_IDLE;
            result_valid_o <= 1'b0;
            busy_o         <= 1'b0;
        end else begin
            state_q        <= state_d;
            result_valid_o <= res_ld_o;  // output register fills on this edge

            if (start_acc) begin
                busy_o <= 1'b1;
            end else if (res_ld_o) begin
                busy_o <= 1'b0;
            end
        end
    end

    // clear and scale load share the start edge
    assign acc_clr_o  = start_acc;
    assign scale_ld_o = start_acc;
    assign acc_en_o   = sample_acc;  // samples outside ST_ACC dropped here
    assign res_ld_o   = (state_q == dq_seq_pkg::ST_CONV);

endmodule

`default_nettype wire

// ==== logic/dq_fmt_pkg.sv ====
`default_nettype none

// number formats and fixed constants of the dequantization path
package dq_fmt_pkg;

    // fp32 fields
    localparam int FP_W     = 32;
    localparam int MANT_W   = 23;
    localparam int EXP_W    = 8;
    localparam int EXP_BIAS = 127;

    // integer datapath
    localparam int ACC_W = 32;  // accumulator, wraps
    localparam int Q_W   = 8;   // int8 samples

    // dequantizer arithmetic
    localparam int SCALE_MANT_W = 15;     // top mantissa bits kept below the hidden one
    localparam int CORR_MULT    = 60773;  // fixed correction factor
    localparam int CORR_SHIFT   = 33;
    localparam int EXP_OFFSET   = 12;     // taken off the exponent sum
    localparam int EXP_MAX      = 254;    // clamp ceiling

    typedef logic        [FP_W-1:0]   fp32_t;
    typedef logic        [MANT_W-1:0] mant_t;
    typedef logic        [EXP_W-1:0]  exp_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic signed [Q_W-1:0]    q8_t;

endpackage

`default_nettype wire

// ==== logic/dq_seq_pkg.sv ====
`default_nettype none

// sequencing of one dot-product operation
package dq_seq_pkg;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // waiting for start
        ST_ACC  = 2'd1,  // taking samples
        ST_CONV = 2'd2   // one cycle, dequantizer loads
    } ctrl_state_t;

    // edges from the last-sample edge to the cycle with result_valid_o high
    localparam int RESULT_LAT = 2;

endpackage

`default_nettype wire

// ==== logic/dq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// dot-product output stage
// dq_ctrl drives the enables, the other three blocks carry data
module dq_top (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  dq_fmt_pkg::fp32_t act_scale_i,
    input  dq_fmt_pkg::fp32_t wgt_scale_i,
    input  logic              sample_valid_i,
    input  dq_fmt_pkg::q8_t   act_i,
    input  dq_fmt_pkg::q8_t   wgt_i,
    input  logic              last_i,
    output dq_fmt_pkg::fp32_t result_o,
    output logic              result_valid_o,
    output logic              busy_o
);

    logic acc_clr;
    logic acc_en;
    logic scale_ld;
    logic res_ld;

    dq_fmt_pkg::acc_t  acc;
    dq_fmt_pkg::mant_t comb_mant;
    dq_fmt_pkg::exp_t  comb_exp;

    dq_ctrl u_ctrl (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .start_i        (start_i),
        .sample_valid_i (sample_valid_i),
        .last_i         (last_i),
        .acc_clr_o      (acc_clr),
        .acc_en_o       (acc_en),
        .scale_ld_o     (scale_ld),
        .res_ld_o       (res_ld),
        .result_valid_o (result_valid_o),
        .busy_o         (busy_o)
    );

    int8_mac u_mac (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .clr_i    (acc_clr),
        .en_i     (acc_en),
        .act_i    (act_i),
        .wgt_i    (wgt_i),
        .acc_o    (acc)
    );

    // scales latched on the start edge
    scale_combine u_scale (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .ld_i        (scale_ld),
        .act_scale_i (act_scale_i),
        .wgt_scale_i (wgt_scale_i),
        .comb_mant_o (comb_mant),
        .comb_exp_o  (comb_exp)
    );

    dequantize_elem u_deq (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .ld_i         (res_ld),
        .acc_i        (acc),
        .mant_scale_i (comb_mant),
        .exp_scale_i  (comb_exp),
        .result_o     (result_o)
    );

endmodule

`default_nettype wire

// ==== logic/int8_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

// int8 x int8 multiply into a wrapping 32-bit accumulator
module int8_mac (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             clr_i,
    input  logic             en_i,
    input  dq_fmt_pkg::q8_t  act_i,
    input  dq_fmt_pkg::q8_t  wgt_i,
    output dq_fmt_pkg::acc_t acc_o
);

    logic signed [2*dq_fmt_pkg::Q_W-1:0] prod;      // full 16-bit product
    dq_fmt_pkg::acc_t                    prod_ext;
    dq_fmt_pkg::acc_t                    acc_q;

    assign prod = act_i * wgt_i;

    // sign extend up to the accumulator width
    assign prod_ext = {{(dq_fmt_pkg::ACC_W - 2*dq_fmt_pkg::Q_W){prod[2*dq_fmt_pkg::Q_W-1]}},
                       prod};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q <= '0;
        end else if (clr_i) begin
            acc_q <= '0;  // clear wins over enable
        end else if (en_i) begin
            acc_q <= acc_q + prod_ext;  // wraps on overflow
        end
    end

    assign acc_o = acc_q;

endmodule

`default_nettype wire

// ==== logic/scale_combine.sv ====
`timescale 1ns/1ps
`default_nettype none

// product of the activation and weight scales as one mantissa/exponent pair
// scales are normal and positive, so sign bits are not looked at
module scale_combine (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              ld_i,
    input  dq_fmt_pkg::fp32_t act_scale_i,
    input  dq_fmt_pkg::fp32_t wgt_scale_i,
    output dq_fmt_pkg::mant_t comb_mant_o,
    output dq_fmt_pkg::exp_t  comb_exp_o
);

    // significands with the hidden one, 24 bits each
    logic [dq_fmt_pkg::MANT_W:0]         act_sig;
    logic [dq_fmt_pkg::MANT_W:0]         wgt_sig;
    logic [2*dq_fmt_pkg::MANT_W+1:0]     sig_prod;  // 48 bits, 2.46 format
    logic                                prod_hi;   // product reached 2.0
    logic [dq_fmt_pkg::EXP_W+1:0]        exp_sum;
    dq_fmt_pkg::mant_t                   mant_d;
    dq_fmt_pkg::exp_t                    exp_d;
    dq_fmt_pkg::mant_t                   mant_q;
    dq_fmt_pkg::exp_t                    exp_q;

    assign act_sig = {1'b1, act_scale_i[dq_fmt_pkg::MANT_W-1:0]};
    assign wgt_sig = {1'b1, wgt_scale_i[dq_fmt_pkg::MANT_W-1:0]};

    assign sig_prod = act_sig * wgt_sig;
    assign prod_hi  = sig_prod[2*dq_fmt_pkg::MANT_W+1];

    // truncate, no rounding
    assign mant_d = prod_hi ? sig_prod[2*dq_fmt_pkg::MANT_W -: dq_fmt_pkg::MANT_W]
                            : sig_prod[2*dq_fmt_pkg::MANT_W-1 -: dq_fmt_pkg::MANT_W];

    // biased exponents added, one bias removed
    assign exp_sum = {2'b00, act_scale_i[dq_fmt_pkg::FP_W-2 -: dq_fmt_pkg::EXP_W]}
                   + {2'b00, wgt_scale_i[dq_fmt_pkg::FP_W-2 -: dq_fmt_pkg::EXP_W]}
                   - (dq_fmt_pkg::EXP_W+2)'(dq_fmt_pkg::EXP_BIAS)
                   + {{(dq_fmt_pkg::EXP_W+1){1'b0}}, prod_hi};

    assign exp_d = exp_sum[dq_fmt_pkg::EXP_W-1:0];  // combined range is 1..254

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mant_q <= '0;
            exp_q  <= '0;
        end else if (ld_i) begin
            mant_q <= mant_d;
            exp_q  <= exp_d;
        end
    end

    assign comb_mant_o = mant_q;
    assign comb_exp_o  = exp_q;

endmodule

`default_nettype wire

// ==== tb/dq_model.svh ====
`ifndef DQ_MODEL_SVH
`define DQ_MODEL_SVH

// reference arithmetic included inside the testbench module

// one step of a 32-bit Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

// truncated combined scale as {exp, mant}
function automatic logic [30:0] combined_scale(input logic [31:0] a_s, input logic [31:0] w_s);
    logic [47:0] p;
    logic [22:0] m;
    int          e;
    p = {24'b0, 1'b1, a_s[22:0]} * {24'b0, 1'b1, w_s[22:0]};
    e = int'(a_s[30:23]) + int'(w_s[30:23]) - dq_fmt_pkg::EXP_BIAS;
    if (p[47]) begin
        m = p[46:24];  // product in [2,4)
        e = e + 1;
    end else begin
        m = p[45:23];
    end
    return {e[7:0], m};
endfunction

// accumulator times combined scale as an fp32 word
function automatic logic [31:0] dequant_ref(input dq_fmt_pkg::acc_t acc,
                                            input logic [30:0] sc);
    logic [31:0] mag;
    logic [63:0] wide;
    logic [30:0] val;
    logic [30:0] nv;
    int          p;
    int          e;
    if (acc == 0) begin
        return '0;
    end
    mag  = acc[31] ? 32'(-acc) : 32'(acc);
    wide = 64'(mag) * 64'({1'b1, sc[22:8]});  // 1 + top 15 mantissa bits
    wide = wide * 64'(dq_fmt_pkg::CORR_MULT);
    val  = 31'(wide >> dq_fmt_pkg::CORR_SHIFT);
    p = 0;
    for (int i = 0; i < 31; i++) begin
        if (val[i]) begin
            p = i;
        end
    end
    if (p >= 23) begin
        nv = val >> (p - 23);
    end else begin
        nv = val << (23 - p);
    end
    e = int'(sc[30:23]) + p - dq_fmt_pkg::EXP_OFFSET;
    if (e < 0) begin
        e = 0;
    end else if (e > dq_fmt_pkg::EXP_MAX) begin
        e = dq_fmt_pkg::EXP_MAX;
    end
    return {acc[31], e[7:0], nv[22:0]};
endfunction

`endif

// ==== tb/tb_dq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dq_top;

    localparam int N_RAND  = 32;  // plus 8 directed operations
    localparam int TIMEOUT = 40 * (2 * 16 + 6) + 200;

    logic              clk_i;
    logic              arst_n_i;
    logic              start_i;
    logic              sample_valid_i;
    logic              last_i;
    logic              result_valid_o;
    logic              busy_o;
    dq_fmt_pkg::fp32_t act_scale_i;
    dq_fmt_pkg::fp32_t wgt_scale_i;
    dq_fmt_pkg::fp32_t result_o;
    dq_fmt_pkg::q8_t   act_i;
    dq_fmt_pkg::q8_t   wgt_i;

    dq_fmt_pkg::q8_t   act_v [16];
    dq_fmt_pkg::q8_t   wgt_v [16];
    dq_fmt_pkg::fp32_t exp_q [$];
    dq_fmt_pkg::fp32_t abs_q [$];
    dq_fmt_pkg::acc_t  sum_q [$];
    dq_fmt_pkg::fp32_t exp_cur;
    dq_fmt_pkg::fp32_t abs_cur;
    dq_fmt_pkg::acc_t  sum_cur;
    logic [31:0] lfsr_q = 32'hd22f_bec5;
    logic exp_last   = 1'b0;
    logic ign_start  = 1'b0;
    logic seen_start = 1'b0;
    logic have_exp   = 1'b0;
    int   mismatch_cnt = 0;
    int   fail_cnt     = 0;
    int   cycle_cnt    = 0;

    `include "dq_model.svh"

    dq_top dut_i (.*);

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // normal positive scale whose exponent 64..190 keeps the combined one in range
    function automatic dq_fmt_pkg::fp32_t rand_scale();
        logic [7:0]  e;
        logic [31:0] m;
        e = 8'(64 + take_bits(7) % 127);
        m = take_bits(23);
        return {1'b0, e, m[22:0]};
    endfunction

    task automatic fill_random(input int len);
        for (int i = 0; i < len; i++) begin
            act_v[i] = dq_fmt_pkg::q8_t'(take_bits(8));
            wgt_v[i] = dq_fmt_pkg::q8_t'(take_bits(8));
        end
    endtask

    task automatic fill_const(input int len, input int a, input int w);
        for (int i = 0; i < len; i++) begin
            act_v[i] = dq_fmt_pkg::q8_t'(a);
            wgt_v[i] = dq_fmt_pkg::q8_t'(w);
        end
    endtask

    // idle strobes with last set that the FSM has to drop
    task automatic strobe_idle(input int n);
        repeat (n) begin
            @(negedge clk_i);
            sample_valid_i = 1'b1;
            act_i  = dq_fmt_pkg::q8_t'(take_bits(8));
            wgt_i  = dq_fmt_pkg::q8_t'(take_bits(8));
            last_i = 1'b1;
        end
        @(negedge clk_i);
        sample_valid_i = 1'b0;
        last_i = 1'b0;
    endtask

    // one operation over act_v/wgt_v that waits for the result strobe
    task automatic run_op(input dq_fmt_pkg::fp32_t a_s, input dq_fmt_pkg::fp32_t w_s,
                          input int len, input bit gaps, input bit extra_start);
        dq_fmt_pkg::acc_t sum;
        logic [30:0]      sc;
        sum = '0;
        sc  = combined_scale(a_s, w_s);
        @(negedge clk_i);
        start_i = 1'b1;
        act_scale_i = a_s;
        wgt_scale_i = w_s;
        seen_start = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        act_scale_i = rand_scale();  // scales already latched so these must not matter
        wgt_scale_i = rand_scale();
        for (int i = 0; i < len; i++) begin
            if ((gaps && take_bits(1) != 0) || (extra_start && i == 0)) begin
                sample_valid_i = 1'b0;
                exp_last = 1'b0;
                start_i = extra_start;
                ign_start = extra_start;
                @(negedge clk_i);
                start_i = 1'b0;
                ign_start = 1'b0;
            end
            sample_valid_i = 1'b1;
            act_i  = act_v[i];
            wgt_i  = wgt_v[i];
            last_i = (i == len - 1);
            exp_last = last_i;
            sum = sum + dq_fmt_pkg::acc_t'(act_v[i]) * dq_fmt_pkg::acc_t'(wgt_v[i]);
            if (last_i) begin
                exp_q.push_back(dequant_ref(sum, sc));
                abs_q.push_back(dequant_ref(-sum, sc));
                sum_q.push_back(sum);
            end
            @(negedge clk_i);
        end
        sample_valid_i = 1'b0;
        last_i = 1'b0;
        exp_last = 1'b0;
        while (!result_valid_o) @(negedge clk_i);
    endtask

    // expected word for the strobe seen at the next rising edge
    always @(negedge clk_i) begin
        if (result_valid_o && exp_q.size() > 0) begin
            exp_cur = exp_q.pop_front();
            abs_cur = abs_q.pop_front();
            sum_cur = sum_q.pop_front();
            have_exp = 1'b1;
        end else begin
            have_exp = 1'b0;
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !seen_start |-> (!result_valid_o && !busy_o && result_o == '0))
        else begin
            fail_cnt++;
            $display("outputs not quiet after reset at %0t", $time);
        end
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        result_valid_o == $past(exp_last, dq_seq_pkg::RESULT_LAT))
        else begin
            fail_cnt++;
            $display("result strobe not %0d edges after last sample at %0t",
                     dq_seq_pkg::RESULT_LAT, $time);
        end
    assert property (@(posedge clk_i) disable iff (!arst_n_i) result_valid_o |-> have_exp)
        else begin
            fail_cnt++;
            $display("result strobe with no pending operation at %0t", $time);
        end
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (result_valid_o && have_exp) |-> result_o == exp_cur)
        else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: result %h, model %h", $time, result_o, exp_cur);
        end
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (result_valid_o && have_exp && sum_cur < 0) |->
        (result_o[31] && result_o[30:0] == abs_cur[30:0]))
        else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: negative sum gives %h, magnitude %h",
                     $time, result_o, abs_cur);
        end
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (result_valid_o && have_exp && sum_cur == 0) |-> result_o == '0)
        else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: zero sum gives %h", $time, result_o);
        end
    assert property (@(posedge clk_i) disable iff (!arst_n_i) ign_start |-> busy_o)
        else begin
            fail_cnt++;
            $display("busy_o low while a second start was driven at %0t", $time);
        end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout after %0d cycles, run stopped", cycle_cnt);
            $display("errors: %0d mismatch, %0d other", mismatch_cnt, fail_cnt + 1);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int len;
        clk_i = 1'b0;
        arst_n_i = 1'b0;
        start_i = 1'b0;
        act_scale_i = '0;
        wgt_scale_i = '0;
        sample_valid_i = 1'b0;
        act_i = '0;
        wgt_i = '0;
        last_i = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        strobe_idle(3);  // idle window before any start
        for (int v = 0; v < N_RAND; v++) begin
            len = 1 + int'(take_bits(4));
            fill_random(len);
            run_op(rand_scale(), rand_scale(), len, 1'b1, 1'b0);
        end
        fill_const(8, 0, 0);
        run_op(rand_scale(), rand_scale(), 8, 1'b0, 1'b0);
        for (int i = 0; i < 6; i++) begin
            act_v[i] = (i % 2 == 0) ? 8'sd37 : -8'sd37;  // pairs cancel
            wgt_v[i] = 8'sd91;
        end
        run_op(rand_scale(), rand_scale(), 6, 1'b1, 1'b0);
        fill_const(16, -128, 127);  // most negative sum
        run_op(rand_scale(), rand_scale(), 16, 1'b0, 1'b0);
        fill_const(3, -5, 77);
        run_op(rand_scale(), rand_scale(), 3, 1'b1, 1'b0);
        fill_const(16, -128, -128);
        run_op(rand_scale(), rand_scale(), 16, 1'b0, 1'b0);
        fill_const(16, 127, 127);  // exponent clamps high
        run_op({1'b0, 8'd190, 23'h7f_ffff}, {1'b0, 8'd190, 23'h7f_ffff}, 16, 1'b0, 1'b0);
        fill_const(1, 3, 5);  // exponent clamps to zero
        run_op({1'b0, 8'd64, 23'd0}, {1'b0, 8'd64, 23'd0}, 1, 1'b0, 1'b0);
        strobe_idle(4);
        fill_random(8);
        run_op(rand_scale(), rand_scale(), 8, 1'b1, 1'b1);
        repeat (4) @(negedge clk_i);
        assert (exp_q.size() == 0)
            else begin
                fail_cnt++;
                $display("%0d expected results never strobed", exp_q.size());
            end
        $display("errors: %0d mismatch, %0d other", mismatch_cnt, fail_cnt);
        if (mismatch_cnt + fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
